//--- dmaTop.f
logic/dmaPkg.sv
logic/regSlave.sv
logic/dmaCtrl.sv
logic/descTracker.sv
logic/burstMover.sv
logic/dmaTop.sv
verification/dmaMemModel.sv
verification/dmaTb.sv

//--- runSim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --timescale 1ns/1ns \
    --top-module dmaTb \
    -f dmaTop.f \
    -o simDma

./obj_dir/simDma | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"

//--- verification/dmaStimulus.txt
# Columns: op addr data, hex. M preload word, C config write, S stall mode,
# I wait interrupt (1 rise, 0 stays low), F interrupt level, E expected word,
# A expected write request (addr len), G expected read request, N end of test
M 040 00000400
M 044 00000800
M 048 00000003
M 04C 00000001
M 400 11111111
M 404 22222222
M 408 33333333
M 050 00000500
M 054 00000900
M 058 0000000A
M 05C 00000001
M 060 00000600
M 064 00000A00
M 068 00000002
M 06C 00000070
M 070 00000700
M 074 00000B00
M 078 00000002
M 07C 00000001
M 0C0 00000500
M 0C4 00000C00
M 0C8 0000000A
M 0CC 00000001
C 200 00000040
C 100 00000001
I 0 1
E 800 11111111
E 804 22222222
E 808 33333333
E 80C C0DE0203
C 100 00000000
N 0 0
C 200 00000050
C 100 00000001
I 0 1
A 900 3
A 910 3
A 920 1
E 900 C0DE0140
E 904 C0DE0141
E 908 C0DE0142
E 90C C0DE0143
E 910 C0DE0144
E 914 C0DE0145
E 918 C0DE0146
E 91C C0DE0147
E 920 C0DE0148
E 924 C0DE0149
C 100 00000000
N 0 0
C 200 00000060
C 100 00000001
I 0 1
G 060 3
G 600 1
G 070 3
G 700 1
E A00 C0DE0180
E A04 C0DE0181
E B00 C0DE01C0
E B04 C0DE01C1
C 100 00000000
N 0 0
C 200 00000040
C 100 00000001
I 0 1
F 0 1
C 100 00000000
F 0 0
C 300 00000001
I 0 0
N 0 0
S 0 1
C 200 000000C0
C 100 00000001
I 0 1
E C00 C0DE0140
E C04 C0DE0141
E C08 C0DE0142
E C0C C0DE0143
E C10 C0DE0144
E C14 C0DE0145
E C18 C0DE0146
E C1C C0DE0147
E C20 C0DE0148
E C24 C0DE0149
C 100 00000000
S 0 0
N 0 0

//--- verification/dmaTb.sv
module dmaTb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int MaxBurst = 4;
    localparam string StimFile = "verification/dmaStimulus.txt";

    logic             clk;
    logic             rst;
    logic             stallOn;
    dmaPkg::cfgWriteT cfgWr;
    logic             cfgAwready;
    logic             cfgWready;
    logic             cfgBvalid;
    logic             cfgBready;
    dmaPkg::addrReqT  arReq;
    logic             arready;
    dmaPkg::dataBeatT rBeat;
    logic             rready;
    dmaPkg::addrReqT  awReq;
    logic             awready;
    dmaPkg::dataBeatT wBeat;
    logic             wready;
    logic             bvalid;
    logic             bready;
    logic             interrupt;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycleLimit = 1000000;

    // Address requests seen on the bus during the current test
    dmaPkg::addrT arAddrQ [$];
    dmaPkg::lenT  arLenQ [$];
    dmaPkg::addrT awAddrQ [$];
    dmaPkg::lenT  awLenQ [$];

    // Write burst being checked for its last flag
    dmaPkg::lenT wrLen = '0;
    dmaPkg::lenT wrBeatIdx = '0;

    dmaTop #(
        .MaxBurst (MaxBurst)
    ) dmaTop_i (
        .clk        (clk),
        .rst        (rst),
        .cfgWr      (cfgWr),
        .cfgAwready (cfgAwready),
        .cfgWready  (cfgWready),
        .cfgBvalid  (cfgBvalid),
        .cfgBready  (cfgBready),
        .arReq      (arReq),
        .arready    (arready),
        .rBeat      (rBeat),
        .rready     (rready),
        .awReq      (awReq),
        .awready    (awready),
        .wBeat      (wBeat),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .interrupt  (interrupt)
    );

    dmaMemModel memModel_i (
        .clk     (clk),
        .stallOn (stallOn),
        .arReq   (arReq),
        .arready (arready),
        .rBeat   (rBeat),
        .rready  (rready),
        .awReq   (awReq),
        .awready (awready),
        .wBeat   (wBeat),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst && arReq.valid && arready) begin
            arAddrQ.push_back(arReq.addr);
            arLenQ.push_back(arReq.len);
        end
        if (!rst && awReq.valid && awready) begin
            awAddrQ.push_back(awReq.addr);
            awLenQ.push_back(awReq.len);
            wrLen     = awReq.len;
            wrBeatIdx = '0;
        end
        // Last flag belongs on beat number len of the burst
        if (!rst && wBeat.valid && wready) begin
            checkFlag("wBeat.last", wBeat.last, wrBeatIdx == wrLen);
            wrBeatIdx = wrBeatIdx + 1'b1;
        end
    end

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic checkData(string name, dmaPkg::dataT got, dmaPkg::dataT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkAddr(string name, dmaPkg::addrT got, dmaPkg::addrT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkLen(string name, dmaPkg::lenT got, dmaPkg::lenT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // One full write on the configuration port
    task automatic cfgWrite(dmaPkg::addrT addr, dmaPkg::dataT data);
        @(posedge clk);
        cfgWr.awvalid <= 1'b1;
        cfgWr.awaddr  <= addr;
        do @(posedge clk); while (!cfgAwready);
        cfgWr.awvalid <= 1'b0;
        cfgWr.wvalid  <= 1'b1;
        cfgWr.wdata   <= data;
        do @(posedge clk); while (!cfgWready);
        cfgWr.wvalid <= 1'b0;
        cfgBready    <= 1'b1;
        do @(posedge clk); while (!cfgBvalid);
        cfgBready <= 1'b0;
    endtask

    task automatic popWriteReq(dmaPkg::addrT addr, dmaPkg::lenT len);
        if (awLenQ.size() == 0) begin
            errors++;
            $display("No write address request was seen where one was expected");
        end else begin
            checkAddr("awReq.addr", awAddrQ.pop_front(), addr);
            checkFlag("awReq.len within MaxBurst", int'(awLenQ[0]) < MaxBurst, 1'b1);
            checkLen("awReq.len", awLenQ.pop_front(), len);
        end
    endtask

    task automatic popReadReq(dmaPkg::addrT addr, dmaPkg::lenT len);
        if (arLenQ.size() == 0) begin
            errors++;
            $display("No read address request was seen where one was expected");
        end else begin
            checkAddr("arReq.addr", arAddrQ.pop_front(), addr);
            checkLen("arReq.len", arLenQ.pop_front(), len);
        end
    endtask

    // Either waits for the interrupt or watches that it stays low
    task automatic waitInterrupt(logic expectRise);
        if (expectRise) begin
            do @(posedge clk); while (!interrupt);
        end else begin
            repeat (50) begin
                @(posedge clk);
                checkFlag("interrupt", interrupt, 1'b0);
                checkFlag("arReq.valid", arReq.valid, 1'b0);
            end
        end
    endtask

    // Sums the expected words and tests to size the timeout
    task automatic sizeTimeout();
        int fd;
        int words;
        int tests;
        string line;
        words = 0;
        tests = 0;
        fd = $fopen(StimFile, "r");
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] == "E") words++;
            if (line.len() > 0 && line[0] == "N") tests++;
        end
        if (fd != 0) $fclose(fd);
        cycleLimit = words * 40 + tests * 200;
    endtask

    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycleLimit) begin
                $display("Run stopped after %0d cycles without finishing", cycles);
                $display("TB FAILED");
                $finish;
            end
        end
    end

    // ============================================================
    // Main sequence driven by the stimulus file
    // ============================================================
    initial begin
        int fd;
        int testNum;
        int testErrors;
        string line;
        logic [7:0] op;
        logic [31:0] a;
        logic [31:0] d;
        rst       = 1'b1;
        stallOn   = 1'b0;
        cfgWr     = '0;
        cfgBready = 1'b0;
        testNum    = 0;
        testErrors = 0;
        sizeTimeout();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen(StimFile, "r");
        if (fd == 0) begin
            errors++;
            $display("Stimulus file could not be opened");
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 3 || line[0] == "#") continue;
            a = '0;
            d = '0;
            void'($sscanf(line, "%c %h %h", op, a, d));
            case (op)
                "M": memModel_i.mem[a[11:2]] = d;
                "C": cfgWrite(a, d);
                "S": stallOn <= d[0];
                "I": waitInterrupt(d[0]);
                "F": checkFlag("interrupt", interrupt, d[0]);
                "E": checkData($sformatf("mem[%h]", a), memModel_i.mem[a[11:2]], d);
                "A": popWriteReq(a, dmaPkg::lenT'(d));
                "G": popReadReq(a, dmaPkg::lenT'(d));
                "N": begin
                    testNum++;
                    $display("Test %0d finished with %0d errors", testNum,
                             errors - testErrors);
                    testErrors = errors;
                    arAddrQ.delete();
                    arLenQ.delete();
                    awAddrQ.delete();
                    awLenQ.delete();
                end
                default: begin
                    errors++;
                    $display("Unknown command in stimulus file: %s", line);
                end
            endcase
        end
        if (fd != 0) $fclose(fd);
        $display("Tests %0d, checks %0d, errors %0d", testNum, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verification/dmaMemModel.sv
module dmaMemModel (
    input  logic             clk,
    input  logic             stallOn,
    input  dmaPkg::addrReqT  arReq,
    output logic             arready,
    output dmaPkg::dataBeatT rBeat,
    input  logic             rready,
    input  dmaPkg::addrReqT  awReq,
    output logic             awready,
    input  dmaPkg::dataBeatT wBeat,
    output logic             wready,
    output logic             bvalid,
    input  logic             bready
);
    timeunit 1ns;
    timeprecision 1ns;

    // Word memory covering byte addresses 0 to 0xFFF
    dmaPkg::dataT mem [1024];
    int seed = 32'he3f1;

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'hC0DE0000 | 32'(i);
        end
    end

    // ============================================================
    // Read side
    // ============================================================
    initial begin
        logic [9:0] idx;
        int beats;
        int gap;
        arready = 1'b0;
        rBeat   = '0;
        forever begin
            @(posedge clk);
            if (arReq.valid && arready) begin
                idx     = arReq.addr[11:2];
                beats   = int'(arReq.len) + 1;
                arready <= 1'b0;
                for (int i = 0; i < beats; i++) begin
                    gap = stallOn ? ($random(seed) & 3) : 0;
                    if (gap > 0) begin
                        rBeat <= '0;
                        repeat (gap) @(posedge clk);
                    end
                    rBeat.valid <= 1'b1;
                    rBeat.data  <= mem[idx];
                    rBeat.last  <= (i == beats - 1);
                    do @(posedge clk); while (!rready);
                    idx = idx + 10'd1;
                end
                rBeat <= '0;
            end else begin
                arready <= stallOn ? ($random(seed) % 2 == 0) : 1'b1;
            end
        end
    end

    // ============================================================
    // Write side
    // ============================================================
    initial begin
        logic [9:0] idx;
        int beats;
        int count;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        forever begin
            @(posedge clk);
            if (awReq.valid && awready) begin
                idx     = awReq.addr[11:2];
                beats   = int'(awReq.len) + 1;
                count   = 0;
                awready <= 1'b0;
                while (count < beats) begin
                    wready <= stallOn ? ($random(seed) % 2 == 0) : 1'b1;
                    @(posedge clk);
                    if (wready && wBeat.valid) begin
                        mem[idx] = wBeat.data;
                        idx      = idx + 10'd1;
                        count++;
                    end
                end
                wready <= 1'b0;
                if (stallOn) repeat ($random(seed) & 3) @(posedge clk);
                bvalid <= 1'b1;
                do @(posedge clk); while (!bready);
                bvalid <= 1'b0;
            end else begin
                awready <= stallOn ? ($random(seed) % 2 == 0) : 1'b1;
            end
        end
    end

endmodule

//--- logic/dmaTop.sv
module dmaTop #(
    parameter int MaxBurst = 16
) (
    input  logic             clk,
    input  logic             rst,

    // ============================================================
    // Configuration slave
    // ============================================================
    input  dmaPkg::cfgWriteT cfgWr,
    output logic             cfgAwready,
    output logic             cfgWready,
    output logic             cfgBvalid,
    input  logic             cfgBready,

    // ============================================================
    // Memory master
    // ============================================================
    output dmaPkg::addrReqT  arReq,
    input  logic             arready,
    input  dmaPkg::dataBeatT rBeat,
    output logic             rready,
    output dmaPkg::addrReqT  awReq,
    input  logic             awready,
    output dmaPkg::dataBeatT wBeat,
    input  logic             wready,
    input  logic             bvalid,
    output logic             bready,
    output logic             interrupt
);

    logic         startPulse;
    logic         stopPulse;
    dmaPkg::addrT descBase;
    dmaPkg::addrT descAddr;
    dmaPkg::addrT burstSrc;
    dmaPkg::addrT burstDst;
    dmaPkg::lenT  burstLen;
    logic         blockDone;
    logic         chainEnd;
    logic         loadWord;
    logic         loadFromBase;
    logic         burstStep;
    logic         moveEnable;
    logic         burstDone;
    logic         respDone;
    logic         descRready;
    logic         moverRready;

    regSlave regSlave_i (
        .clk        (clk),
        .rst        (rst),
        .cfgWr      (cfgWr),
        .awready    (cfgAwready),
        .wready     (cfgWready),
        .bvalid     (cfgBvalid),
        .bready     (cfgBready),
        .startPulse (startPulse),
        .stopPulse  (stopPulse),
        .descBase   (descBase)
    );

    dmaCtrl #(
        .MaxBurst (MaxBurst)
    ) dmaCtrl_i (
        .clk          (clk),
        .rst          (rst),
        .startPulse   (startPulse),
        .stopPulse    (stopPulse),
        .descAddr     (descAddr),
        .burstSrc     (burstSrc),
        .burstDst     (burstDst),
        .burstLen     (burstLen),
        .blockDone    (blockDone),
        .chainEnd     (chainEnd),
        .arReq        (arReq),
        .arready      (arready),
        .awReq        (awReq),
        .awready      (awready),
        .descRready   (descRready),
        .rBeat        (rBeat),
        .loadWord     (loadWord),
        .loadFromBase (loadFromBase),
        .burstStep    (burstStep),
        .moveEnable   (moveEnable),
        .burstDone    (burstDone),
        .respDone     (respDone),
        .interrupt    (interrupt)
    );

    descTracker #(
        .MaxBurst (MaxBurst)
    ) descTracker_i (
        .clk          (clk),
        .rst          (rst),
        .descBase     (descBase),
        .loadFromBase (loadFromBase),
        .loadWord     (loadWord),
        .rData        (rBeat.data),
        .burstStep    (burstStep),
        .descAddr     (descAddr),
        .burstSrc     (burstSrc),
        .burstDst     (burstDst),
        .burstLen     (burstLen),
        .blockDone    (blockDone),
        .chainEnd     (chainEnd)
    );

    burstMover burstMover_i (
        .clk        (clk),
        .rst        (rst),
        .moveEnable (moveEnable),
        .rBeat      (rBeat),
        .rready     (moverRready),
        .wBeat      (wBeat),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .burstDone  (burstDone),
        .respDone   (respDone)
    );

    // Descriptor fetch and data phase never overlap
    assign rready = descRready | moverRready;

endmodule

//--- logic/burstMover.sv
module burstMover (
    input  logic             clk,
    input  logic             rst,
    input  logic             moveEnable,
    input  dmaPkg::dataBeatT rBeat,
    output logic             rready,
    output dmaPkg::dataBeatT wBeat,
    input  logic             wready,
    input  logic             bvalid,
    output logic             bready,
    output logic             burstDone,
    output logic             respDone
);

    dmaPkg::lenT beatCount;
    logic        beatHs;

    // Shared back-pressure, a stall on either side holds both
    assign rready = moveEnable && wready;

    always_comb begin
        wBeat.valid = moveEnable && rBeat.valid;
        wBeat.data  = rBeat.data;
        wBeat.last  = rBeat.last;
    end

    assign beatHs    = wBeat.valid && wready;
    assign burstDone = beatHs && rBeat.last;
    assign respDone  = bready && bvalid;

    // Beats within the current burst
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beatCount <= '0;
        end else if (burstDone) begin
            beatCount <= '0;
        end else if (beatHs) begin
            beatCount <= beatCount + 1'b1;
        end
    end

    // Response accepted from the last beat on
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bready <= 1'b0;
        end else if (burstDone) begin
            bready <= 1'b1;
        end else if (respDone) begin
            bready <= 1'b0;
        end
    end

    // The 16th beat of a burst must carry last
    assert property (@(posedge clk) disable iff (rst)
        (beatHs && (beatCount == '1)) |-> rBeat.last);

    // Data phase closes before the response is awaited
    assert property (@(posedge clk) disable iff (rst)
        wBeat.valid |-> moveEnable && !bready);

endmodule

//--- logic/descTracker.sv
module descTracker #(
    parameter int MaxBurst = 16
) (
    input  logic         clk,
    input  logic         rst,
    input  dmaPkg::addrT descBase,
    input  logic         loadFromBase,
    input  logic         loadWord,
    input  dmaPkg::dataT rData,
    input  logic         burstStep,
    output dmaPkg::addrT descAddr,
    output dmaPkg::addrT burstSrc,
    output dmaPkg::addrT burstDst,
    output dmaPkg::lenT  burstLen,
    output logic         blockDone,
    output logic         chainEnd
);

    localparam dmaPkg::countT MaxBeats = dmaPkg::countT'(MaxBurst);
    localparam int IdxBits = $clog2(dmaPkg::DescWords);

    logic [IdxBits-1:0] wordIdx;
    logic               lastWord;
    dmaPkg::countT      remaining;
    dmaPkg::countT      burstBeats;
    dmaPkg::addrT       stepBytes;

    // Source, destination and length until the next pointer arrives
    dmaPkg::dataT descWord [dmaPkg::DescWords-1];

    assign lastWord = loadWord && (wordIdx == IdxBits'(dmaPkg::DescWords - 1));

    always_ff @(posedge clk) begin
        if (loadWord && !lastWord) descWord[wordIdx] <= rData;
    end

    // ============================================================
    // Block progress
    // ============================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wordIdx   <= '0;
            remaining <= '0;
            chainEnd  <= 1'b0;
        end else begin
            if (loadFromBase) begin
                wordIdx <= '0;
            end else if (loadWord) begin
                wordIdx <= wordIdx + 1'b1;
            end
            if (lastWord) begin
                remaining <= dmaPkg::countT'(descWord[2]);
                chainEnd  <= rData[0];
            end else if (burstStep) begin
                remaining <= remaining - burstBeats;
            end
        end
    end

    // Pointer and working addresses
    always_ff @(posedge clk) begin
        if (loadFromBase) begin
            descAddr <= descBase;
        end else if (lastWord) begin
            descAddr <= {rData[31:1], 1'b0};
        end
        if (lastWord) begin
            burstSrc <= descWord[0];
            burstDst <= descWord[1];
        end else if (burstStep) begin
            burstSrc <= burstSrc + stepBytes;
            burstDst <= burstDst + stepBytes;
        end
    end

    // Next burst is the smaller of what is left and MaxBurst
    assign burstBeats = (remaining > MaxBeats) ? MaxBeats : remaining;
    assign burstLen   = dmaPkg::lenT'(burstBeats - 1'b1);
    assign stepBytes  = dmaPkg::addrT'(burstBeats) << 2;
    assign blockDone  = (remaining == '0);

endmodule

//--- logic/dmaCtrl.sv
module dmaCtrl #(
    parameter int MaxBurst = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             startPulse,
    input  logic             stopPulse,
    input  dmaPkg::addrT     descAddr,
    input  dmaPkg::addrT     burstSrc,
    input  dmaPkg::addrT     burstDst,
    input  dmaPkg::lenT      burstLen,
    input  logic             blockDone,
    input  logic             chainEnd,
    output dmaPkg::addrReqT  arReq,
    input  logic             arready,
    output dmaPkg::addrReqT  awReq,
    input  logic             awready,
    output logic             descRready,
    input  dmaPkg::dataBeatT rBeat,
    output logic             loadWord,
    output logic             loadFromBase,
    output logic             burstStep,
    output logic             moveEnable,
    input  logic             burstDone,
    input  logic             respDone,
    output logic             interrupt
);

    dmaPkg::ctrlStateT state;
    dmaPkg::ctrlStateT nextState;

    // Per-channel accepted flags for the transfer address phase
    logic arDone;
    logic awDone;
    logic arHs;
    logic awHs;
    logic rHs;
    logic xferAccepted;

    assign arHs         = arReq.valid && arready;
    assign awHs         = awReq.valid && awready;
    assign rHs          = rBeat.valid && descRready;
    assign xferAccepted = (arDone || arHs) && (awDone || awHs);

    // ============================================================
    // State machine
    // ============================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= dmaPkg::Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            dmaPkg::Idle: begin
                if (startPulse) nextState = dmaPkg::DescAddr;
            end
            dmaPkg::DescAddr: begin
                if (arHs) nextState = dmaPkg::DescData;
            end
            dmaPkg::DescData: begin
                if (rHs && rBeat.last) nextState = dmaPkg::XferAddr;
            end
            dmaPkg::XferAddr: begin
                if (xferAccepted) nextState = dmaPkg::XferData;
            end
            dmaPkg::XferData: begin
                if (burstDone) nextState = dmaPkg::WriteResp;
            end
            dmaPkg::WriteResp: begin
                if (respDone) begin
                    if (!blockDone) begin
                        nextState = dmaPkg::XferAddr;
                    end else if (chainEnd) begin
                        nextState = dmaPkg::Done;
                    end else begin
                        nextState = dmaPkg::DescAddr;
                    end
                end
            end
            dmaPkg::Done: begin
                if (stopPulse) nextState = dmaPkg::Idle;
            end
            default: begin
                nextState = dmaPkg::Idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arDone <= 1'b0;
            awDone <= 1'b0;
        end else if ((state == dmaPkg::XferAddr) && !xferAccepted) begin
            arDone <= arDone || arHs;
            awDone <= awDone || awHs;
        end else begin
            arDone <= 1'b0;
            awDone <= 1'b0;
        end
    end

    // ============================================================
    // Address requests
    // ============================================================

    always_comb begin
        arReq = '0;
        awReq = '0;
        case (state)
            dmaPkg::DescAddr: begin
                arReq.valid = 1'b1;
                arReq.addr  = descAddr;
                arReq.len   = dmaPkg::lenT'(dmaPkg::DescWords - 1);
            end
            dmaPkg::XferAddr: begin
                arReq.valid = !arDone;
                arReq.addr  = burstSrc;
                arReq.len   = burstLen;
                awReq.valid = !awDone;
                awReq.addr  = burstDst;
                awReq.len   = burstLen;
            end
            default: begin
                arReq = '0;
                awReq = '0;
            end
        endcase
    end

    // Read data goes to the tracker only while fetching a descriptor
    assign descRready   = (state == dmaPkg::DescData);
    assign loadWord     = rHs;
    assign loadFromBase = (state == dmaPkg::Idle) && startPulse;
    assign moveEnable   = (state == dmaPkg::XferData);
    assign burstStep    = moveEnable && burstDone;
    assign interrupt    = (state == dmaPkg::Done);

    // Read address held with its payload until accepted
    assert property (@(posedge clk) disable iff (rst)
        (arReq.valid && !arready) |=> arReq.valid && $stable(arReq.addr));

    // Tracker never sizes a burst beyond MaxBurst
    assert property (@(posedge clk) disable iff (rst)
        awReq.valid |-> (int'(awReq.len) < MaxBurst));

endmodule

//--- logic/regSlave.sv
module regSlave (
    input  logic             clk,
    input  logic             rst,
    input  dmaPkg::cfgWriteT cfgWr,
    output logic             awready,
    output logic             wready,
    output logic             bvalid,
    input  logic             bready,
    output logic             startPulse,
    output logic             stopPulse,
    output dmaPkg::addrT     descBase
);

    typedef enum logic [1:0] {
        Accept,
        Data,
        Resp
    } slaveStateT;

    slaveStateT   state;
    dmaPkg::addrT wrAddr;
    logic         wrHs;
    logic         enableHit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= Accept;
        end else begin
            case (state)
                Accept: begin
                    if (cfgWr.awvalid) state <= Data;
                end
                Data: begin
                    if (cfgWr.wvalid) state <= Resp;
                end
                Resp: begin
                    if (bready) state <= Accept;
                end
                default: begin
                    state <= Accept;
                end
            endcase
        end
    end

    // Address held for the data phase
    always_ff @(posedge clk) begin
        if (awready && cfgWr.awvalid) wrAddr <= cfgWr.awaddr;
    end

    assign awready = (state == Accept);
    assign wready  = (state == Data);
    assign bvalid  = (state == Resp);

    // Register decode on the data handshake
    assign wrHs       = cfgWr.wvalid && wready;
    assign enableHit  = wrHs && (wrAddr == dmaPkg::EnableOffset);
    assign startPulse = enableHit && cfgWr.wdata[0];
    assign stopPulse  = enableHit && !cfgWr.wdata[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            descBase <= '0;
        end else if (wrHs && (wrAddr == dmaPkg::DescBaseOffset)) begin
            descBase <= cfgWr.wdata;
        end
    end

    // Write data held with its payload until accepted
    assert property (@(posedge clk) disable iff (rst)
        (cfgWr.wvalid && !wready) |=> cfgWr.wvalid && $stable(cfgWr.wdata));

endmodule

//--- logic/dmaPkg.sv
package dmaPkg;

    // ============================================================
    // Widths
    // ============================================================

    // Byte address on the memory bus
    typedef logic [31:0] addrT;

    // Full data word, always transferred whole
    typedef logic [31:0] dataT;

    // Burst length field, beats minus 1
    typedef logic [3:0] lenT;

    // Block length in words
    typedef logic [15:0] countT;

    // ============================================================
    // Register map and descriptor layout
    // ============================================================

    localparam addrT EnableOffset   = 32'h100;
    localparam addrT DescBaseOffset = 32'h200;

    // Source, destination, length, next pointer
    localparam int DescWords = 4;

    // ============================================================
    // Channel bundles
    // ============================================================

    // Read or write address request
    typedef struct packed {
        logic valid;
        addrT addr;
        lenT  len;
    } addrReqT;

    // One beat of read or write data
    typedef struct packed {
        logic valid;
        dataT data;
        logic last;
    } dataBeatT;

    // Configuration write, address and data channels
    typedef struct packed {
        logic awvalid;
        addrT awaddr;
        logic wvalid;
        dataT wdata;
    } cfgWriteT;

    // Controller sequencing
    typedef enum logic [2:0] {
        Idle,
        DescAddr,
        DescData,
        XferAddr,
        XferData,
        WriteResp,
        Done
    } ctrlStateT;

endpackage
